// File: design/dfd_trace_pkg.sv
/* Shared widths, depths and enums of the debug trace sink.
   Modules pull these in by a wildcard import in their headers. */

package dfd_trace_pkg;

  // One trace entry as seen at the input
  localparam int TRACE_ENTRY_W = 32;

  // Two entries share one memory row
  localparam int TRACE_ROW_W = 64;

  // 512 rows of storage
  localparam int TRACE_ADDR_W = 9;

  // Entry index, bit 0 picks the row half and the upper bits the row
  localparam int TRACE_IDX_W = 10;

  // Total entries held, also the saturation point of the write count
  localparam int TRACE_DEPTH = 1 << TRACE_IDX_W;

  // Count has one more bit so it can reach TRACE_DEPTH
  localparam int TRACE_CNT_W = TRACE_IDX_W + 1;

  // One write mask bit per row half
  localparam int TRACE_MASK_W = 2;

  // Memory read latency in cycles, grant to data on the port
  localparam int TRACE_RD_LATENCY = 3;

  // Capture behaviour once the memory has been filled
  typedef enum logic {
    CAP_WRAP = 1'b0,  // Keep going and overwrite the oldest entries
    CAP_STOP = 1'b1   // Freeze after the last entry
  } capture_mode_e;

  // Readout request holding
  typedef enum logic {
    RD_IDLE       = 1'b0,
    RD_WAIT_GRANT = 1'b1
  } rd_state_e;

endpackage

// File: design/trace_mem_model.sv
/* Behavioural single-port trace memory with a per-half write mask.
   A read is sampled on one edge and its row appears on the output three edges later. */

`timescale 1ns/1ps

module trace_mem_model
  import dfd_trace_pkg::*;
#(
  parameter int ADDR_WIDTH = TRACE_ADDR_W,
  parameter int DATA_WIDTH = TRACE_ROW_W
) (
  input  logic                                i_clk,
  input  logic                                i_reset_n,
  input  logic                                i_mem_chip_en,
  input  logic                                i_mem_wr_en,
  input  logic [ADDR_WIDTH-1:0]               i_mem_addr,
  input  logic [DATA_WIDTH/TRACE_ENTRY_W-1:0] i_mem_wr_mask_en,
  input  logic [DATA_WIDTH-1:0]               i_mem_wr_data,
  output logic [DATA_WIDTH-1:0]               o_mem_rd_data
);

  // One mask bit per entry-sized slice of the row
  localparam int MASK_W   = DATA_WIDTH / TRACE_ENTRY_W;
  localparam int NUM_ROWS = 1 << ADDR_WIDTH;

  // Row storage
  logic [DATA_WIDTH-1:0] mem_data [NUM_ROWS];

  // Array read latch, loaded on the edge that samples the read
  logic [DATA_WIDTH-1:0] rd_lat_q;
  logic                  rd_lat_vld_q;

  // Two pipeline stages behind the latch
  logic [DATA_WIDTH-1:0] rd_pipe0_q;
  logic [DATA_WIDTH-1:0] rd_pipe1_q;
  logic                  rd_vld0_q;
  logic                  rd_vld1_q;

  logic rd_launch;
  logic wr_launch;

  // Port cycle decode
  assign wr_launch = i_mem_chip_en & i_mem_wr_en;
  assign rd_launch = i_mem_chip_en & ~i_mem_wr_en;

  // Masked write, each set bit updates its own slice only
  always_ff @(posedge i_clk) begin
    if (wr_launch) begin
      for (int m = 0; m < MASK_W; m++) begin
        if (i_mem_wr_mask_en[m]) begin
          mem_data[i_mem_addr][m*TRACE_ENTRY_W +: TRACE_ENTRY_W] <=
            i_mem_wr_data[m*TRACE_ENTRY_W +: TRACE_ENTRY_W];
        end
      end
    end
  end

  // Read pipeline
  always_ff @(posedge i_clk) begin
    if (!i_reset_n) begin
      rd_lat_q      <= '0;
      rd_lat_vld_q  <= 1'b0;
      rd_pipe0_q    <= '0;
      rd_pipe1_q    <= '0;
      rd_vld0_q     <= 1'b0;
      rd_vld1_q     <= 1'b0;
      o_mem_rd_data <= '0;
    end else begin
      // Row content is taken at the sampling edge
      // so a later write to the same row does not leak into this read
      rd_lat_vld_q <= rd_launch;
      if (rd_launch) begin
        rd_lat_q <= mem_data[i_mem_addr];
      end

      // Stage 0 and stage 1
      rd_pipe0_q <= rd_lat_q;
      rd_vld0_q  <= rd_lat_vld_q;
      rd_pipe1_q <= rd_pipe0_q;
      rd_vld1_q  <= rd_vld0_q;

      // Output moves only when a read matures, otherwise it holds
      if (rd_vld1_q) begin
        o_mem_rd_data <= rd_pipe1_q;
      end
    end
  end

endmodule

// File: design/trace_capture_ctrl.sv
/* Trace capture side, packs 32-bit entries two per row through the write mask.
   Tracks the write pointer, the entry count and the wrap and full flags. */

`timescale 1ns/1ps

module trace_capture_ctrl
  import dfd_trace_pkg::*;
(
  input  logic                     i_clk,
  input  logic                     i_reset_n,
  input  logic                     i_trace_valid,
  input  logic [TRACE_ENTRY_W-1:0] i_trace_data,
  input  logic                     i_capture_en,
  input  capture_mode_e            i_capture_mode,
  input  logic                     i_capture_clear,
  output logic                     o_wr_req,
  output logic [TRACE_ADDR_W-1:0]  o_wr_row,
  output logic [TRACE_MASK_W-1:0]  o_wr_mask,
  output logic [TRACE_ROW_W-1:0]   o_wr_data,
  output logic [TRACE_CNT_W-1:0]   o_wr_count,
  output logic                     o_wrapped,
  output logic                     o_full
);

  // Entry staged for the write one cycle after its strobe
  logic                     stg_valid_q;
  logic [TRACE_ENTRY_W-1:0] stg_data_q;
  logic                     stg_stop_q;

  // Index of the entry being written by the staged write
  logic [TRACE_IDX_W-1:0]   wr_ptr_q;
  logic [TRACE_CNT_W-1:0]   wr_count_q;
  logic                     wrapped_q;
  logic                     full_q;

  logic last_entry;
  logic fill_pend;
  logic accept;

  // Staged write lands on the final entry slot
  assign last_entry = &wr_ptr_q;

  // Stop-mode write of entry 1023 is in flight, so the memory is full next cycle
  assign fill_pend = stg_valid_q & stg_stop_q & last_entry;

  // Entries are dropped only in stop mode once full
  always_comb begin
    accept = i_trace_valid & i_capture_en;
    if (i_capture_mode == CAP_STOP && (full_q || fill_pend)) begin
      accept = 1'b0;
    end
  end

  // Control state
  always_ff @(posedge i_clk) begin
    if (!i_reset_n) begin
      stg_valid_q <= 1'b0;
      wr_ptr_q    <= '0;
      wr_count_q  <= '0;
      wrapped_q   <= 1'b0;
      full_q      <= 1'b0;
    end else if (i_capture_clear) begin
      // Clear wins over a strobe in the same cycle
      stg_valid_q <= 1'b0;
      wr_ptr_q    <= '0;
      wr_count_q  <= '0;
      wrapped_q   <= 1'b0;
      full_q      <= 1'b0;
    end else begin
      stg_valid_q <= accept;
      // Pointer, count and flags follow the write itself
      if (stg_valid_q) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
        if (wr_count_q != TRACE_CNT_W'(TRACE_DEPTH)) begin
          wr_count_q <= wr_count_q + 1'b1;
        end
        if (last_entry) begin
          if (stg_stop_q) begin
            full_q <= 1'b1;
          end else begin
            wrapped_q <= 1'b1;
          end
        end
      end
    end
  end

  // Entry payload and the mode it arrived under
  always_ff @(posedge i_clk) begin
    if (accept) begin
      stg_data_q <= i_trace_data;
      stg_stop_q <= (i_capture_mode == CAP_STOP);
    end
  end

  // Write port, one cycle per staged entry
  assign o_wr_req  = stg_valid_q;
  assign o_wr_row  = wr_ptr_q[TRACE_IDX_W-1:1];
  // Pointer bit 0 picks the half, only that half is enabled
  assign o_wr_mask = TRACE_MASK_W'(1) << wr_ptr_q[0];
  // Entry copied into both halves, the mask decides which one sticks
  assign o_wr_data = {TRACE_MASK_W{stg_data_q}};

  // Status
  assign o_wr_count = wr_count_q;
  assign o_wrapped  = wrapped_q;
  assign o_full     = full_q;

endmodule

// File: design/trace_readout_ctrl.sv
/* Host readout side, holds one read request until granted and selects the entry half.
   Granted reads are tracked through the memory latency by a short shift register. */

`timescale 1ns/1ps

module trace_readout_ctrl
  import dfd_trace_pkg::*;
(
  input  logic                     i_clk,
  input  logic                     i_reset_n,
  input  logic                     i_rd_req,
  input  logic [TRACE_IDX_W-1:0]   i_rd_idx,
  input  logic                     i_rd_grant,
  input  logic [TRACE_ROW_W-1:0]   i_mem_rd_data,
  output logic                     o_rd_req_pend,
  output logic [TRACE_ADDR_W-1:0]  o_rd_row,
  output logic                     o_rd_valid,
  output logic [TRACE_ENTRY_W-1:0] o_rd_data,
  output logic                     o_rd_busy
);

  // Memory latency plus the half-select register
  localparam int SR_LEN = TRACE_RD_LATENCY + 1;

  rd_state_e state_q;

  // Held request
  logic [TRACE_ADDR_W-1:0] req_row_q;
  logic                    req_half_q;

  // Reads in flight, bit 0 is the newest grant
  logic [SR_LEN-1:0] vld_sr_q;
  logic [SR_LEN-1:0] half_sr_q;

  logic req_take;

  // New requests only while idle, others are ignored
  assign req_take = (state_q == RD_IDLE) & i_rd_req;

  // Request FSM
  always_ff @(posedge i_clk) begin
    if (!i_reset_n) begin
      state_q <= RD_IDLE;
    end else begin
      case (state_q)
        RD_IDLE: begin
          if (i_rd_req) begin
            state_q <= RD_WAIT_GRANT;
          end
        end
        RD_WAIT_GRANT: begin
          // Grant is a single pulse, the request is done with
          if (i_rd_grant) begin
            state_q <= RD_IDLE;
          end
        end
        default: state_q <= RD_IDLE;
      endcase
    end
  end

  // Request address and half
  always_ff @(posedge i_clk) begin
    if (req_take) begin
      req_row_q  <= i_rd_idx[TRACE_IDX_W-1:1];
      req_half_q <= i_rd_idx[0];
    end
  end

  // In-flight tracking and output register
  always_ff @(posedge i_clk) begin
    if (!i_reset_n) begin
      vld_sr_q   <= '0;
      o_rd_valid <= 1'b0;
    end else begin
      vld_sr_q   <= {vld_sr_q[SR_LEN-2:0], i_rd_grant};
      // Oldest stage lines up with the matured memory output
      o_rd_valid <= vld_sr_q[SR_LEN-1];
    end
  end

  // Half bits travel with the valid bits
  always_ff @(posedge i_clk) begin
    half_sr_q <= {half_sr_q[SR_LEN-2:0], req_half_q};
    if (vld_sr_q[SR_LEN-1]) begin
      o_rd_data <= i_mem_rd_data[half_sr_q[SR_LEN-1]*TRACE_ENTRY_W +: TRACE_ENTRY_W];
    end
  end

  assign o_rd_req_pend = (state_q == RD_WAIT_GRANT);
  assign o_rd_row      = req_row_q;
  // Busy only until the grant, later reads overlap in the pipeline
  assign o_rd_busy     = (state_q == RD_WAIT_GRANT);

endmodule

// File: design/trace_port_arb.sv
/* Combinational arbiter for the single trace memory port.
   Capture writes always win and a pending read is granted in the first free cycle. */

`timescale 1ns/1ps

module trace_port_arb
  import dfd_trace_pkg::*;
(
  input  logic                    i_wr_req,
  input  logic [TRACE_ADDR_W-1:0] i_wr_row,
  input  logic [TRACE_MASK_W-1:0] i_wr_mask,
  input  logic [TRACE_ROW_W-1:0]  i_wr_data,
  input  logic                    i_rd_req_pend,
  input  logic [TRACE_ADDR_W-1:0] i_rd_row,
  output logic                    o_rd_grant,
  output logic                    o_mem_chip_en,
  output logic                    o_mem_wr_en,
  output logic [TRACE_ADDR_W-1:0] o_mem_addr,
  output logic [TRACE_MASK_W-1:0] o_mem_wr_mask,
  output logic [TRACE_ROW_W-1:0]  o_mem_wr_data
);

  // Trace entries are never delayed, reads take the leftover cycles
  assign o_rd_grant = i_rd_req_pend & ~i_wr_req;

  always_comb begin
    // Idle port by default
    o_mem_chip_en = 1'b0;
    o_mem_wr_en   = 1'b0;
    o_mem_addr    = i_rd_row;
    o_mem_wr_mask = '0;
    if (i_wr_req) begin
      o_mem_chip_en = 1'b1;
      o_mem_wr_en   = 1'b1;
      o_mem_addr    = i_wr_row;
      o_mem_wr_mask = i_wr_mask;
    end else if (i_rd_req_pend) begin
      // Grant and memory read share this cycle
      o_mem_chip_en = 1'b1;
    end
  end

  // Ignored by the memory unless write enable is set
  assign o_mem_wr_data = i_wr_data;

endmodule

// File: design/dfd_trace_sink.sv
/* Debug trace sink top, capture and readout share one trace memory port.
   Instances and wiring only. */

`timescale 1ns/1ps

module dfd_trace_sink
  import dfd_trace_pkg::*;
(
  input  logic                     i_clk,
  input  logic                     i_reset_n,
  input  logic                     i_trace_valid,
  input  logic [TRACE_ENTRY_W-1:0] i_trace_data,
  input  logic                     i_capture_en,
  input  capture_mode_e            i_capture_mode,
  input  logic                     i_capture_clear,
  input  logic                     i_rd_req,
  input  logic [TRACE_IDX_W-1:0]   i_rd_idx,
  output logic                     o_rd_valid,
  output logic [TRACE_ENTRY_W-1:0] o_rd_data,
  output logic                     o_rd_busy,
  output logic [TRACE_CNT_W-1:0]   o_wr_count,
  output logic                     o_wrapped,
  output logic                     o_full
);

  // Capture to arbiter
  logic                    wr_req;
  logic [TRACE_ADDR_W-1:0] wr_row;
  logic [TRACE_MASK_W-1:0] wr_mask;
  logic [TRACE_ROW_W-1:0]  wr_data;

  // Readout and arbiter
  logic                    rd_req_pend;
  logic [TRACE_ADDR_W-1:0] rd_row;
  logic                    rd_grant;

  // Memory port
  logic                    mem_chip_en;
  logic                    mem_wr_en;
  logic [TRACE_ADDR_W-1:0] mem_addr;
  logic [TRACE_MASK_W-1:0] mem_wr_mask;
  logic [TRACE_ROW_W-1:0]  mem_wr_data;
  logic [TRACE_ROW_W-1:0]  mem_rd_data;

  trace_capture_ctrl i_trace_capture_ctrl (
    .i_clk           (i_clk),
    .i_reset_n       (i_reset_n),
    .i_trace_valid   (i_trace_valid),
    .i_trace_data    (i_trace_data),
    .i_capture_en    (i_capture_en),
    .i_capture_mode  (i_capture_mode),
    .i_capture_clear (i_capture_clear),
    .o_wr_req        (wr_req),
    .o_wr_row        (wr_row),
    .o_wr_mask       (wr_mask),
    .o_wr_data       (wr_data),
    .o_wr_count      (o_wr_count),
    .o_wrapped       (o_wrapped),
    .o_full          (o_full)
  );

  trace_readout_ctrl i_trace_readout_ctrl (
    .i_clk         (i_clk),
    .i_reset_n     (i_reset_n),
    .i_rd_req      (i_rd_req),
    .i_rd_idx      (i_rd_idx),
    .i_rd_grant    (rd_grant),
    .i_mem_rd_data (mem_rd_data),
    .o_rd_req_pend (rd_req_pend),
    .o_rd_row      (rd_row),
    .o_rd_valid    (o_rd_valid),
    .o_rd_data     (o_rd_data),
    .o_rd_busy     (o_rd_busy)
  );

  trace_port_arb i_trace_port_arb (
    .i_wr_req      (wr_req),
    .i_wr_row      (wr_row),
    .i_wr_mask     (wr_mask),
    .i_wr_data     (wr_data),
    .i_rd_req_pend (rd_req_pend),
    .i_rd_row      (rd_row),
    .o_rd_grant    (rd_grant),
    .o_mem_chip_en (mem_chip_en),
    .o_mem_wr_en   (mem_wr_en),
    .o_mem_addr    (mem_addr),
    .o_mem_wr_mask (mem_wr_mask),
    .o_mem_wr_data (mem_wr_data)
  );

  // 512 x 64 trace store
  trace_mem_model #(
    .ADDR_WIDTH (TRACE_ADDR_W),
    .DATA_WIDTH (TRACE_ROW_W)
  ) i_trace_mem_model (
    .i_clk            (i_clk),
    .i_reset_n        (i_reset_n),
    .i_mem_chip_en    (mem_chip_en),
    .i_mem_wr_en      (mem_wr_en),
    .i_mem_addr       (mem_addr),
    .i_mem_wr_mask_en (mem_wr_mask),
    .i_mem_wr_data    (mem_wr_data),
    .o_mem_rd_data    (mem_rd_data)
  );

endmodule

// File: verif/dfd_trace_sink_properties.sv
/* Concurrent assertions on trace port arbitration and readout timing.
   Bound into the sink top, where the arbiter and readout signals meet. */

`timescale 1ns/1ps

module dfd_trace_sink_properties
  import dfd_trace_pkg::*;
(
  input logic i_clk,
  input logic i_reset_n,
  input logic i_wr_req,
  input logic i_rd_grant,
  input logic i_mem_chip_en,
  input logic i_rd_valid
);

  // Memory latency plus the half-select register
  localparam int GRANT_TO_VALID = TRACE_RD_LATENCY + 1;

  // Assertion failures so far
  int fail_count = 0;

  // Writes always win the port
  a_wr_grant_excl: assert property (
    @(posedge i_clk) disable iff (!i_reset_n) !(i_wr_req && i_rd_grant))
    else begin
      fail_count++;
      $error("Read grant given in a write cycle");
    end

  // Every grant matures into exactly one valid pulse
  // The valid register loads GRANT_TO_VALID edges after the grant edge
  // and the next edge samples it
  a_grant_to_valid: assert property (
    @(posedge i_clk) disable iff (!i_reset_n)
      i_rd_grant |=> ##GRANT_TO_VALID i_rd_valid)
    else begin
      fail_count++;
      $error("o_rd_valid missing four cycles after a grant");
    end

  // No valid pulse without its grant
  a_valid_from_grant: assert property (
    @(posedge i_clk) disable iff (!i_reset_n)
      i_rd_valid |-> $past(i_rd_grant, GRANT_TO_VALID + 1))
    else begin
      fail_count++;
      $error("o_rd_valid without a grant four cycles earlier");
    end

  // Port stays quiet once reset has been seen on an edge
  a_reset_quiet: assert property (
    @(posedge i_clk) !i_reset_n |=> (i_reset_n || !i_mem_chip_en))
    else begin
      fail_count++;
      $error("Memory chip enable active during reset");
    end

endmodule

bind dfd_trace_sink dfd_trace_sink_properties i_dfd_trace_sink_properties (
  .i_clk         (i_clk),
  .i_reset_n     (i_reset_n),
  .i_wr_req      (wr_req),
  .i_rd_grant    (rd_grant),
  .i_mem_chip_en (mem_chip_en),
  .i_rd_valid    (o_rd_valid)
);

// File: verif/tb_dfd_trace_sink.sv
/* Directed testbench for the debug trace sink with a capture reference model.
   Runs reset, readback, wrap, stop and overlapped read tests, then prints a status line. */

`timescale 1ns/1ps

module tb_dfd_trace_sink
  import dfd_trace_pkg::*;
();

  localparam int unsigned SEED = 15297;
  // Two fills of 1030 entries plus about 110 reads of up to 12 cycles and a wide margin
  localparam int TIMEOUT_CYCLES = 20000;

  logic                     i_clk = 1'b0;
  logic                     i_reset_n;
  logic                     i_trace_valid;
  logic [TRACE_ENTRY_W-1:0] i_trace_data;
  logic                     i_capture_en;
  capture_mode_e            i_capture_mode;
  logic                     i_capture_clear;
  logic                     i_rd_req;
  logic [TRACE_IDX_W-1:0]   i_rd_idx;
  logic                     o_rd_valid;
  logic [TRACE_ENTRY_W-1:0] o_rd_data;
  logic                     o_rd_busy;
  logic [TRACE_CNT_W-1:0]   o_wr_count;
  logic                     o_wrapped;
  logic                     o_full;

  // Capture reference model
  logic [TRACE_ENTRY_W-1:0] model_mem [TRACE_DEPTH];
  int                       model_ptr;
  int                       model_count;
  logic                     model_wrapped;
  logic                     model_full;

  // Entries of the last burst, read results and their expected values
  logic [TRACE_ENTRY_W-1:0] sent_q [$];
  logic [TRACE_ENTRY_W-1:0] rd_q [$];
  logic [TRACE_ENTRY_W-1:0] exp_q [$];

  int err_count;
  int test_count;
  int fail_count;
  int cycle_count;

  always #2 i_clk = ~i_clk;

  dfd_trace_sink i_dfd_trace_sink (
    .i_clk           (i_clk),
    .i_reset_n       (i_reset_n),
    .i_trace_valid   (i_trace_valid),
    .i_trace_data    (i_trace_data),
    .i_capture_en    (i_capture_en),
    .i_capture_mode  (i_capture_mode),
    .i_capture_clear (i_capture_clear),
    .i_rd_req        (i_rd_req),
    .i_rd_idx        (i_rd_idx),
    .o_rd_valid      (o_rd_valid),
    .o_rd_data       (o_rd_data),
    .o_rd_busy       (o_rd_busy),
    .o_wr_count      (o_wr_count),
    .o_wrapped       (o_wrapped),
    .o_full          (o_full)
  );

  // Read results are taken mid-cycle while the registered outputs are steady
  always @(negedge i_clk) begin
    if (i_reset_n && o_rd_valid) begin
      rd_q.push_back(o_rd_data);
    end
  end

  // Watchdog
  always @(posedge i_clk) begin
    cycle_count++;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Run stopped after %0d cycles without finishing the tests", cycle_count);
      $display("STATUS: FAIL");
      $finish;
    end
  end

  task automatic compare_values(input string name, input logic [63:0] actual,
                                input logic [63:0] expected);
    if (actual !== expected) begin
      $display("Mismatch %s: got 0x%0h, expected 0x%0h", name, actual, expected);
      err_count++;
    end
  endtask

  // Stop mode drops entries once full and the pointer wraps at the depth
  task automatic model_capture(input logic [TRACE_ENTRY_W-1:0] data, input capture_mode_e mode);
    if (!(mode == CAP_STOP && model_full)) begin
      model_mem[model_ptr] = data;
      if (model_count < TRACE_DEPTH) begin
        model_count++;
      end
      if (model_ptr == TRACE_DEPTH - 1) begin
        if (mode == CAP_STOP) begin
          model_full = 1'b1;
        end else begin
          model_wrapped = 1'b1;
        end
      end
      model_ptr = (model_ptr + 1) % TRACE_DEPTH;
    end
  endtask

  task automatic push_entry(input logic [TRACE_ENTRY_W-1:0] data, input capture_mode_e mode);
    @(posedge i_clk);
    i_trace_valid  <= 1'b1;
    i_trace_data   <= data;
    i_capture_mode <= mode;
    model_capture(data, mode);
  endtask

  // Full-rate burst that returns once the last write has landed
  task automatic send_entries(input int n, input capture_mode_e mode);
    logic [TRACE_ENTRY_W-1:0] data;
    sent_q.delete();
    for (int k = 0; k < n; k++) begin
      data = $urandom;
      sent_q.push_back(data);
      push_entry(data, mode);
    end
    @(posedge i_clk);
    i_trace_valid <= 1'b0;
    repeat (2) @(posedge i_clk);
  endtask

  task automatic clear_capture();
    @(posedge i_clk);
    i_capture_clear <= 1'b1;
    @(posedge i_clk);
    i_capture_clear <= 1'b0;
    model_ptr     = 0;
    model_count   = 0;
    model_wrapped = 1'b0;
    model_full    = 1'b0;
  endtask

  // Sends one request pulse and waits until the grant drops o_rd_busy
  task automatic issue_read(input int idx, input logic [TRACE_ENTRY_W-1:0] expected);
    exp_q.push_back(expected);
    @(posedge i_clk);
    i_rd_req <= 1'b1;
    i_rd_idx <= TRACE_IDX_W'(idx);
    @(posedge i_clk);
    i_rd_req <= 1'b0;
    @(negedge i_clk);
    while (o_rd_busy) begin
      @(negedge i_clk);
    end
  endtask

  // Results must arrive in request order
  task automatic collect_reads();
    logic [TRACE_ENTRY_W-1:0] got;
    logic [TRACE_ENTRY_W-1:0] want;
    while (rd_q.size() < exp_q.size()) begin
      @(negedge i_clk);
    end
    while (exp_q.size() > 0) begin
      got  = rd_q.pop_front();
      want = exp_q.pop_front();
      compare_values("o_rd_data", got, want);
    end
    repeat (8) @(negedge i_clk);
    if (rd_q.size() != 0) begin
      $display("Readout gave %0d more results than were requested", rd_q.size());
      err_count++;
      rd_q.delete();
    end
  endtask

  task automatic finish_test(input string name, input int start_errs);
    test_count++;
    if (err_count == start_errs) begin
      $display("%s: passed", name);
    end else begin
      fail_count++;
      $display("%s: failed with %0d errors", name, err_count - start_errs);
    end
  endtask

  task automatic reset_values();
    int start;
    start = err_count;
    @(negedge i_clk);
    compare_values("o_rd_valid", o_rd_valid, 0);
    compare_values("o_rd_busy", o_rd_busy, 0);
    compare_values("o_wrapped", o_wrapped, 0);
    compare_values("o_full", o_full, 0);
    compare_values("o_wr_count", o_wr_count, 0);
    finish_test("reset_values", start);
  endtask

  task automatic readback_basic();
    int start;
    start = err_count;
    send_entries(40, CAP_WRAP);
    @(negedge i_clk);
    compare_values("o_wr_count", o_wr_count, model_count);
    for (int k = 0; k < 40; k++) begin
      issue_read(k, model_mem[k]);
    end
    collect_reads();
    finish_test("readback_basic", start);
  endtask

  task automatic wrap_overwrite();
    int start;
    start = err_count;
    clear_capture();
    send_entries(1030, CAP_WRAP);
    @(negedge i_clk);
    compare_values("o_wrapped", o_wrapped, model_wrapped);
    compare_values("o_full", o_full, model_full);
    compare_values("o_wr_count", o_wr_count, model_count);
    // First six slots hold the second lap and slot 6 is still from the first
    for (int k = 0; k < 6; k++) begin
      issue_read(k, sent_q[TRACE_DEPTH + k]);
    end
    issue_read(6, sent_q[6]);
    collect_reads();
    finish_test("wrap_overwrite", start);
  endtask

  task automatic stop_when_full();
    int start;
    start = err_count;
    clear_capture();
    send_entries(1030, CAP_STOP);
    @(negedge i_clk);
    compare_values("o_full", o_full, model_full);
    compare_values("o_wrapped", o_wrapped, model_wrapped);
    compare_values("o_wr_count", o_wr_count, model_count);
    issue_read(0, sent_q[0]);
    issue_read(TRACE_DEPTH - 1, sent_q[TRACE_DEPTH - 1]);
    collect_reads();
    finish_test("stop_when_full", start);
  endtask

  // Reads target the first 100 entries while new ones land above them
  task automatic reads_under_traffic();
    int start;
    int idx;
    start = err_count;
    clear_capture();
    send_entries(100, CAP_WRAP);
    fork
      begin
        for (int c = 0; c < 200; c++) begin
          if ($urandom_range(3, 0) != 0) begin
            push_entry($urandom, CAP_WRAP);
          end else begin
            @(posedge i_clk);
            i_trace_valid <= 1'b0;
          end
        end
        @(posedge i_clk);
        i_trace_valid <= 1'b0;
      end
      begin
        for (int r = 0; r < 20; r++) begin
          idx = $urandom_range(99, 0);
          issue_read(idx, model_mem[idx]);
        end
      end
    join
    collect_reads();
    finish_test("reads_under_traffic", start);
  endtask

  // Back-to-back requests with several reads in flight
  task automatic pipelined_reads();
    int start;
    int idx;
    start = err_count;
    for (int r = 0; r < 32; r++) begin
      idx = $urandom_range(TRACE_DEPTH - 1, 0);
      issue_read(idx, model_mem[idx]);
    end
    collect_reads();
    finish_test("pipelined_reads", start);
  endtask

  initial begin
    i_reset_n       = 1'b0;
    i_trace_valid   = 1'b0;
    i_trace_data    = '0;
    i_capture_en    = 1'b0;
    i_capture_mode  = CAP_WRAP;
    i_capture_clear = 1'b0;
    i_rd_req        = 1'b0;
    i_rd_idx        = '0;
    model_ptr       = 0;
    model_count     = 0;
    model_wrapped   = 1'b0;
    model_full      = 1'b0;
    void'($urandom(SEED));
    repeat (5) @(posedge i_clk);
    i_reset_n    <= 1'b1;
    i_capture_en <= 1'b1;

    reset_values();
    readback_basic();
    wrap_overwrite();
    stop_when_full();
    reads_under_traffic();
    pipelined_reads();

    if (i_dfd_trace_sink.i_dfd_trace_sink_properties.fail_count != 0) begin
      $display("%0d assertion failures in the bound properties",
               i_dfd_trace_sink.i_dfd_trace_sink_properties.fail_count);
      err_count += i_dfd_trace_sink.i_dfd_trace_sink_properties.fail_count;
    end
    $display("Tests run: %0d, tests failed: %0d, errors: %0d", test_count, fail_count, err_count);
    if (err_count == 0 && fail_count == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

// File: files.f
design/dfd_trace_pkg.sv
design/trace_mem_model.sv
design/trace_capture_ctrl.sv
design/trace_readout_ctrl.sv
design/trace_port_arb.sv
design/dfd_trace_sink.sv
verif/dfd_trace_sink_properties.sv
verif/tb_dfd_trace_sink.sv

// File: Bender.yml
package:
  name: dfd_trace_sink

dependencies: {}

sources:
  - files:
      - design/dfd_trace_pkg.sv
      - design/trace_mem_model.sv
      - design/trace_capture_ctrl.sv
      - design/trace_readout_ctrl.sv
      - design/trace_port_arb.sv
      - design/dfd_trace_sink.sv
  - target: simulation
    files:
      - verif/dfd_trace_sink_properties.sv
      - verif/tb_dfd_trace_sink.sv
